// ==== sources.f ====
rtl/rv_pkg.sv
rtl/rv_state.sv
rtl/rv_decode.sv
rtl/rv_alu.sv
rtl/rv_pc.sv
rtl/rv_mem_if.sv
rtl/rv_regfile.sv
rtl/rv_serial_core.sv
tests/tb_rv_serial_core.sv

// ==== Makefile ====
BIN := obj_dir/Vtb_rv_serial_core

$(BIN): sources.f $(shell cat sources.f)
	verilator --binary --assert -Wno-fatal -f sources.f --top-module tb_rv_serial_core

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx 'Finished with no errors'

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== tests/tb_rv_serial_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_rv_serial_core;
   import rv_pkg::*;

   localparam word_t RESET_PC   = 32'h0000_0200;
   localparam word_t NOP_INSN   = 32'h0000_0013;
   localparam int    WAIT_LIMIT = 2000;
   localparam int    Q_FETCH    = 0;
   localparam int    Q_STORE    = 1;
   localparam int    Q_LOAD     = 2;

   logic   clk = 1'b0;
   logic   rst_n = 1'b0;
   word_t  ibus_adr;
   logic   ibus_cyc;
   word_t  ibus_rdt = '0;
   logic   ibus_ack = 1'b0;
   word_t  dbus_adr;
   word_t  dbus_dat;
   logic   dbus_we;
   logic   dbus_cyc;
   word_t  dbus_rdt = '0;
   logic   dbus_ack = 1'b0;

   word_t  rom [0:255];
   word_t  dmem [0:255];
   word_t  fetch_q [$];
   word_t  store_adr_q [$];
   word_t  store_dat_q [$];
   word_t  load_adr_q [$];
   integer seed = 13150;
   int     ibus_wait = 0;
   int     dbus_wait = 0;
   int     pc_idx = 0;
   int     errors = 0;
   int     checks = 0;
   int     tests = 0;
   logic   timed_out = 1'b0;

   rv_serial_core #(
      .RESET_PC (RESET_PC)
   ) u_rv_serial_core (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .o_dbus_we  (dbus_we),
      .o_dbus_cyc (dbus_cyc),
      .i_dbus_rdt (dbus_rdt),
      .i_dbus_ack (dbus_ack)
   );

   always #4 clk = ~clk;

   function automatic int next_wait();
      return $unsigned($random(seed)) % 4;
   endfunction

   function automatic int mem_index(input word_t adr);
      return int'(adr[9:2]);
   endfunction

   // Instruction and data bus models that ack after 0 to 3 idle cycles
   always @(negedge clk) begin
      if (!rst_n) begin
         ibus_ack <= 1'b0;
         dbus_ack <= 1'b0;
         ibus_wait = next_wait();
         dbus_wait = next_wait();
      end else begin
         if (ibus_ack) begin
            ibus_ack <= 1'b0;
         end else if (ibus_cyc) begin
            if (ibus_wait == 0) begin
               ibus_ack <= 1'b1;
               ibus_rdt <= rom[mem_index(ibus_adr)];
               fetch_q.push_back(ibus_adr);
               ibus_wait = next_wait();
            end else begin
               ibus_wait = ibus_wait - 1;
            end
         end
         if (dbus_ack) begin
            dbus_ack <= 1'b0;
         end else if (dbus_cyc) begin
            if (dbus_wait == 0) begin
               dbus_ack <= 1'b1;
               if (dbus_we) begin
                  dmem[mem_index(dbus_adr)] = dbus_dat;
                  store_adr_q.push_back(dbus_adr);
                  store_dat_q.push_back(dbus_dat);
               end else begin
                  dbus_rdt <= dmem[mem_index(dbus_adr)];
                  load_adr_q.push_back(dbus_adr);
               end
               dbus_wait = next_wait();
            end else begin
               dbus_wait = dbus_wait - 1;
            end
         end
      end
   end

   // RV32I encoders
   function automatic word_t enc_addi(input int rd, input int rs1, input int imm);
      return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
   endfunction

   function automatic word_t enc_alu(input int f7, input int f3, input int rd, input int rs1,
                                     input int rs2);
      return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
   endfunction

   function automatic word_t enc_lui(input int rd, input int imm20);
      return {20'(imm20), 5'(rd), 7'b0110111};
   endfunction

   function automatic word_t enc_lw(input int rd, input int rs1, input int imm);
      return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
   endfunction

   function automatic word_t enc_sw(input int rs2, input int rs1, input int imm);
      word_t v;
      v = imm;
      return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], 7'b0100011};
   endfunction

   function automatic word_t enc_branch(input int f3, input int rs1, input int rs2, input int imm);
      word_t v;
      v = imm;
      return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], 7'b1100011};
   endfunction

   function automatic word_t enc_jal(input int rd, input int imm);
      word_t v;
      v = imm;
      return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111};
   endfunction

   task automatic compare_word(input word_t got, input word_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s data 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
   endtask

   task automatic compare_addr(input word_t got, input word_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s address 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
   endtask

   task automatic compare_bit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic place(input int idx, input word_t ins);
      rom[mem_index(RESET_PC + 4 * idx)] = ins;
   endtask

   task automatic emit(input word_t ins);
      place(pc_idx, ins);
      pc_idx++;
   endtask

   // LUI plus ADDI with the upper part rounded for the sign of the low twelve bits
   task automatic emit_const(input int rd, input word_t value);
      word_t hi;
      hi = value + 32'h800;
      emit(enc_lui(rd, int'(hi[31:12])));
      emit(enc_addi(rd, rd, int'(value[11:0])));
   endtask

   task automatic begin_program();
      @(negedge clk);
      rst_n <= 1'b0;
      @(negedge clk);
      for (int i = 0; i < 256; i++) begin
         rom[i] = NOP_INSN;
         dmem[i] = 32'h5A5A_0000 ^ (i * 4);
      end
      pc_idx = 0;
   endtask

   task automatic release_reset();
      repeat (9) @(negedge clk);
      compare_bit(ibus_cyc, 1'b1, "ibus cycle in reset");
      compare_bit(dbus_cyc, 1'b0, "dbus cycle in reset");
      compare_bit(dbus_we, 1'b0, "dbus write enable in reset");
      compare_addr(ibus_adr, RESET_PC, "reset fetch");
      fetch_q.delete();
      store_adr_q.delete();
      store_dat_q.delete();
      load_adr_q.delete();
      rst_n <= 1'b1;
   endtask

   function automatic int pending(input int kind);
      case (kind)
         Q_FETCH: return fetch_q.size();
         Q_STORE: return store_adr_q.size();
         default: return load_adr_q.size();
      endcase
   endfunction

   task automatic wait_for(input int kind, input string what);
      int n;
      n = 0;
      while (!timed_out && pending(kind) == 0) begin
         if (n == WAIT_LIMIT) begin
            timed_out = 1'b1;
            $display("Timeout at %0t ns: the core made no %s within %0d cycles",
                     $time, what, WAIT_LIMIT);
         end else begin
            @(posedge clk);
            n++;
         end
      end
   endtask

   task automatic expect_fetch(input word_t adr);
      wait_for(Q_FETCH, "instruction fetch");
      if (!timed_out)
         compare_addr(fetch_q.pop_front(), adr, "fetch");
   endtask

   task automatic expect_load(input word_t adr);
      wait_for(Q_LOAD, "load");
      if (!timed_out)
         compare_addr(load_adr_q.pop_front(), adr, "load");
   endtask

   task automatic expect_store(input word_t adr, input word_t dat, input string what);
      wait_for(Q_STORE, "store");
      if (!timed_out) begin
         compare_addr(store_adr_q.pop_front(), adr, what);
         compare_word(store_dat_q.pop_front(), dat, what);
      end
   endtask

   task automatic finish_test(input string name, input int err_start);
      tests++;
      if (timed_out)
         $display("Test %-10s stopped by timeout", name);
      else if (errors == err_start)
         $display("Test %-10s passed", name);
      else
         $display("Test %-10s failed with %0d errors", name, errors - err_start);
   endtask

   task automatic test_arith();
      int err_start;
      err_start = errors;
      begin_program();
      emit(enc_addi(1, 0, 100));
      emit(enc_addi(2, 0, -7));
      emit(enc_alu(7'h00, 0, 3, 1, 2));
      emit(enc_alu(7'h20, 0, 4, 2, 1));
      emit_const(7, 32'hFFFF_FFF0);
      emit(enc_addi(8, 7, 32));
      emit_const(9, 32'h8000_0000);
      emit(enc_alu(7'h20, 0, 10, 9, 1));
      emit(enc_sw(3, 0, 16));
      emit(enc_sw(4, 0, 20));
      emit(enc_sw(8, 0, 24));
      emit(enc_sw(10, 0, 28));
      release_reset();
      expect_fetch(RESET_PC);
      expect_store(32'd16, 32'd100 + 32'hFFFF_FFF9, "add");
      expect_store(32'd20, 32'hFFFF_FFF9 - 32'd100, "sub");
      expect_store(32'd24, 32'hFFFF_FFF0 + 32'd32, "addi wrap");
      expect_store(32'd28, 32'h8000_0000 - 32'd100, "sub wrap");
      finish_test("arith", err_start);
   endtask

   task automatic test_logic();
      int    err_start;
      word_t a;
      word_t b;
      err_start = errors;
      a = $random(seed);
      b = $random(seed);
      begin_program();
      emit_const(1, a);
      emit_const(2, b);
      emit(enc_alu(7'h00, 7, 3, 1, 2));
      emit(enc_alu(7'h00, 6, 4, 1, 2));
      emit(enc_alu(7'h00, 4, 5, 1, 2));
      emit(enc_sw(3, 0, 32));
      emit(enc_sw(4, 0, 36));
      emit(enc_sw(5, 0, 40));
      release_reset();
      expect_store(32'd32, a & b, "and");
      expect_store(32'd36, a | b, "or");
      expect_store(32'd40, a ^ b, "xor");
      finish_test("logic", err_start);
   endtask

   task automatic test_load();
      int    err_start;
      word_t r;
      err_start = errors;
      r = $random(seed);
      begin_program();
      dmem[mem_index(32'h0000_1300)] = r;
      emit(enc_lui(1, 1));
      emit(enc_lw(2, 1, 'h300));
      emit(enc_sw(2, 1, 'h104));
      release_reset();
      expect_load((32'd1 << 12) + 32'h300);
      expect_store((32'd1 << 12) + 32'h104, r, "load copy");
      finish_test("load", err_start);
   endtask

   task automatic test_branch();
      int err_start;
      err_start = errors;
      begin_program();
      place(0, enc_addi(1, 0, 7));
      place(1, enc_addi(2, 0, 7));
      place(2, enc_addi(3, 0, -3));
      place(3, enc_branch(0, 1, 2, 16));
      place(4, enc_branch(1, 1, 2, 100));
      place(7, enc_branch(0, 1, 3, 40));
      place(8, enc_branch(1, 1, 3, -16));
      release_reset();
      expect_fetch(RESET_PC);
      expect_fetch(RESET_PC + 4);
      expect_fetch(RESET_PC + 8);
      expect_fetch(RESET_PC + 12);
      // Taken BEQ, untaken BEQ, taken BNE backwards, untaken BNE
      expect_fetch(RESET_PC + 12 + 16);
      expect_fetch(RESET_PC + 28 + 4);
      expect_fetch(RESET_PC + 32 - 16);
      expect_fetch(RESET_PC + 16 + 4);
      finish_test("branch", err_start);
   endtask

   task automatic test_jal();
      int err_start;
      err_start = errors;
      begin_program();
      emit(enc_addi(1, 0, 1));
      emit(enc_jal(5, 24));
      place(7, enc_sw(5, 0, 80));
      place(8, enc_jal(0, -28));
      release_reset();
      expect_fetch(RESET_PC);
      expect_fetch(RESET_PC + 4);
      expect_fetch(RESET_PC + 4 + 24);
      expect_fetch(RESET_PC + 28 + 4);
      expect_fetch(RESET_PC + 32 - 28);
      expect_store(32'd80, RESET_PC + 4 + 4, "link");
      finish_test("jal", err_start);
   endtask

   task automatic test_x0_nop();
      int err_start;
      err_start = errors;
      begin_program();
      emit(enc_addi(0, 0, 'h123));
      emit(enc_sw(0, 0, 64));
      emit(enc_addi(1, 0, 5));
      // SLL is not in the subset
      emit(enc_alu(7'h00, 1, 6, 1, 1));
      emit(enc_sw(6, 0, 68));
      release_reset();
      expect_fetch(RESET_PC);
      expect_fetch(RESET_PC + 4);
      expect_fetch(RESET_PC + 8);
      expect_fetch(RESET_PC + 12);
      expect_fetch(RESET_PC + 12 + 4);
      expect_store(32'd64, 32'd0, "x0");
      expect_store(32'd68, 32'd0, "unsupported rd");
      finish_test("x0_nop", err_start);
   endtask

   initial begin
      test_arith();
      if (!timed_out)
         test_logic();
      if (!timed_out)
         test_load();
      if (!timed_out)
         test_branch();
      if (!timed_out)
         test_jal();
      if (!timed_out)
         test_x0_nop();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== rtl/rv_serial_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_serial_core #(
   parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
   input  wire                 clk,
   input  wire                 i_rst_n,
   output rv_pkg::word_t       o_ibus_adr,
   output logic                o_ibus_cyc,
   input  wire rv_pkg::word_t  i_ibus_rdt,
   input  wire                 i_ibus_ack,
   output rv_pkg::word_t       o_dbus_adr,
   output rv_pkg::word_t       o_dbus_dat,
   output logic                o_dbus_we,
   output logic                o_dbus_cyc,
   input  wire rv_pkg::word_t  i_dbus_rdt,
   input  wire                 i_dbus_ack
);
   import rv_pkg::*;

   cnt_t       cnt;
   op_e        op;
   logic       exec;
   logic       branch_pass;
   logic       wb;
   logic       rd_wen;
   logic [4:0] rd_addr;
   logic [4:0] rs1_addr;
   logic [4:0] rs2_addr;
   logic       imm;
   logic       rs1;
   logic       rs2;
   logic       alu_rd;
   logic       take_branch;
   logic       link;
   logic       mem_rd;

   rv_state u_state (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_ibus_ack    (i_ibus_ack),
      .i_dbus_ack    (i_dbus_ack),
      .i_op          (op),
      .o_cnt         (cnt),
      .o_exec        (exec),
      .o_branch_pass (branch_pass),
      .o_wb          (wb),
      .o_rd_wen      (rd_wen),
      .o_ibus_cyc    (o_ibus_cyc),
      .o_dbus_cyc    (o_dbus_cyc),
      .o_dbus_we     (o_dbus_we)
   );

   rv_decode u_decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_cnt      (cnt),
      .o_op       (op),
      .o_rd_addr  (rd_addr),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_imm      (imm)
   );

   rv_regfile u_regfile (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt      (cnt),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_wen   (rd_wen),
      .i_rd       (alu_rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   rv_alu u_alu (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_op          (op),
      .i_cnt         (cnt),
      .i_exec        (exec),
      .i_wb          (wb),
      .i_rs1         (rs1),
      .i_rs2         (rs2),
      .i_imm         (imm),
      .i_link        (link),
      .i_mem_rd      (mem_rd),
      .o_rd          (alu_rd),
      .o_take_branch (take_branch)
   );

   rv_pc #(
      .RESET_PC (RESET_PC)
   ) u_pc (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_op          (op),
      .i_cnt         (cnt),
      .i_exec        (exec),
      .i_branch_pass (branch_pass),
      .i_take_branch (take_branch),
      .i_imm         (imm),
      .o_link        (link),
      .o_ibus_adr    (o_ibus_adr)
   );

   // Address sum reaches the memory interface through the rd bit
   rv_mem_if u_mem_if (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_op       (op),
      .i_exec     (exec),
      .i_wb       (wb),
      .i_alu_sum  (alu_rd),
      .i_rs2      (rs2),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_mem_rd   (mem_rd)
   );

endmodule

`default_nettype wire

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
   input  wire                clk,
   input  wire                i_rst_n,
   input  wire rv_pkg::cnt_t  i_cnt,
   input  wire [4:0]          i_rs1_addr,
   input  wire [4:0]          i_rs2_addr,
   input  wire [4:0]          i_rd_addr,
   input  wire                i_rd_wen,
   input  wire                i_rd,
   output logic               o_rs1,
   output logic               o_rs2
);
   import rv_pkg::*;

   word_t regs [0:31];

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end else if (i_rd_wen && (i_rd_addr != 5'd0)) begin
         regs[i_rd_addr][i_cnt] <= i_rd;
      end
   end

   // Entry zero is cleared by reset and never written
   assign o_rs1 = regs[i_rs1_addr][i_cnt];
   assign o_rs2 = regs[i_rs2_addr][i_cnt];

   a_x0_zero: assert property (@(posedge clk) disable iff (!i_rst_n)
      !((i_rs1_addr == 5'd0) && o_rs1) && !((i_rs2_addr == 5'd0) && o_rs2));

endmodule

`default_nettype wire

// ==== rtl/rv_mem_if.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_mem_if (
   input  wire                 clk,
   input  wire                 i_rst_n,
   input  wire rv_pkg::op_e    i_op,
   input  wire                 i_exec,
   input  wire                 i_wb,
   input  wire                 i_alu_sum,
   input  wire                 i_rs2,
   input  wire rv_pkg::word_t  i_dbus_rdt,
   input  wire                 i_dbus_ack,
   output rv_pkg::word_t       o_dbus_adr,
   output rv_pkg::word_t       o_dbus_dat,
   output logic                o_mem_rd
);
   import rv_pkg::*;

   word_t adr_q;
   word_t dat_q;
   word_t rdt_q;
   logic  is_lw;
   logic  is_sw;

   assign is_lw = (i_op == OP_LW);
   assign is_sw = (i_op == OP_SW);

   // Address and store data arrive LSB first during the main pass
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         adr_q <= '0;
         dat_q <= '0;
      end else if (i_exec && (is_lw || is_sw)) begin
         adr_q <= {i_alu_sum, adr_q[31:1]};
         if (is_sw)
            dat_q <= {i_rs2, dat_q[31:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_dbus_ack && is_lw)
         rdt_q <= i_dbus_rdt;
      else if (i_wb)
         rdt_q <= {1'b0, rdt_q[31:1]};
   end

   // Word access only
   assign o_dbus_adr = {adr_q[31:2], 2'b00};
   assign o_dbus_dat = dat_q;
   assign o_mem_rd   = rdt_q[0];

endmodule

`default_nettype wire

// ==== rtl/rv_pc.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_pc #(
   parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
   input  wire                clk,
   input  wire                i_rst_n,
   input  wire rv_pkg::op_e   i_op,
   input  wire rv_pkg::cnt_t  i_cnt,
   input  wire                i_exec,
   input  wire                i_branch_pass,
   input  wire                i_take_branch,
   input  wire                i_imm,
   output logic               o_link,
   output rv_pkg::word_t      o_ibus_adr
);
   import rv_pkg::*;

   word_t pc_q;
   logic  pc_bit;
   logic  first;
   logic  four_bit;
   logic  c4_in;
   logic  c4_q;
   logic  ct_in;
   logic  ct_q;
   logic  plus4;
   logic  target;
   logic  is_branch;
   logic  shift_en;
   logic  new_bit;

   assign pc_bit    = pc_q[0];
   assign first     = (i_cnt == 5'd0);
   assign four_bit  = (i_cnt == 5'd2);
   assign c4_in     = first ? 1'b0 : c4_q;
   assign ct_in     = first ? 1'b0 : ct_q;
   assign plus4     = pc_bit ^ four_bit ^ c4_in;
   assign target    = pc_bit ^ i_imm ^ ct_in;
   assign is_branch = (i_op == OP_BEQ) || (i_op == OP_BNE);
   assign shift_en  = i_exec | i_branch_pass;

   always_comb begin
      if (i_branch_pass)
         new_bit = i_take_branch ? target : plus4;
      else if (is_branch)
         new_bit = pc_bit;   // rotate unchanged, branch pass decides
      else if (i_op == OP_JAL)
         new_bit = target;
      else
         new_bit = plus4;
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc_q <= RESET_PC;
         c4_q <= 1'b0;
         ct_q <= 1'b0;
      end else if (shift_en) begin
         pc_q <= {new_bit, pc_q[31:1]};
         c4_q <= (pc_bit & four_bit) | (c4_in & (pc_bit ^ four_bit));
         ct_q <= (pc_bit & i_imm) | (ct_in & (pc_bit ^ i_imm));
      end
   end

   assign o_link     = plus4;
   assign o_ibus_adr = pc_q;

endmodule

`default_nettype wire

// ==== rtl/rv_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
   input  wire                clk,
   input  wire                i_rst_n,
   input  wire rv_pkg::op_e   i_op,
   input  wire rv_pkg::cnt_t  i_cnt,
   input  wire                i_exec,
   input  wire                i_wb,
   input  wire                i_rs1,
   input  wire                i_rs2,
   input  wire                i_imm,
   input  wire                i_link,
   input  wire                i_mem_rd,
   output logic               o_rd,
   output logic               o_take_branch
);
   import rv_pkg::*;

   logic first;
   logic sub;
   logic use_rs2;
   logic op_b;
   logic b_eff;
   logic carry_in;
   logic carry_q;
   logic sum;
   logic eq_in;
   logic eq_q;
   logic eq_next;

   assign first   = (i_cnt == 5'd0);
   assign sub     = (i_op == OP_SUB);
   assign use_rs2 = (i_op == OP_ADD) || (i_op == OP_SUB) || (i_op == OP_AND) ||
                    (i_op == OP_OR) || (i_op == OP_XOR) ||
                    (i_op == OP_BEQ) || (i_op == OP_BNE);
   assign op_b    = use_rs2 ? i_rs2 : i_imm;

   // Subtract as a + ~b + 1 with the carry preset on bit zero
   assign b_eff    = op_b ^ sub;
   assign carry_in = first ? sub : carry_q;
   assign sum      = i_rs1 ^ b_eff ^ carry_in;

   assign eq_in   = first ? 1'b1 : eq_q;
   assign eq_next = eq_in & ~(i_rs1 ^ i_rs2);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry_q       <= 1'b0;
         eq_q          <= 1'b0;
         o_take_branch <= 1'b0;
      end else if (i_exec) begin
         carry_q <= (i_rs1 & b_eff) | (carry_in & (i_rs1 ^ b_eff));
         eq_q    <= eq_next;
         if (i_cnt == 5'd31)
            o_take_branch <= ((i_op == OP_BEQ) && eq_next) || ((i_op == OP_BNE) && !eq_next);
      end
   end

   always_comb begin
      if (i_wb) begin
         o_rd = i_mem_rd;
      end else begin
         case (i_op)
            OP_AND:  o_rd = i_rs1 & op_b;
            OP_OR:   o_rd = i_rs1 | op_b;
            OP_XOR:  o_rd = i_rs1 ^ op_b;
            OP_LUI:  o_rd = i_imm;
            OP_JAL:  o_rd = i_link;
            default: o_rd = sum;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== rtl/rv_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
   input  wire                 clk,
   input  wire                 i_rst_n,
   input  wire rv_pkg::word_t  i_ibus_rdt,
   input  wire                 i_ibus_ack,
   input  wire rv_pkg::cnt_t   i_cnt,
   output rv_pkg::op_e         o_op,
   output logic [4:0]          o_rd_addr,
   output logic [4:0]          o_rs1_addr,
   output logic [4:0]          o_rs2_addr,
   output logic                o_imm
);
   import rv_pkg::*;

   word_t      ir;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_u;
   word_t      imm_j;
   word_t      imm_sel;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   always_ff @(posedge clk) begin
      if (!i_rst_n)
         ir <= '0;
      else if (i_ibus_ack)
         ir <= i_ibus_rdt;
   end

   assign opcode = ir[6:0];
   assign funct3 = ir[14:12];
   assign funct7 = ir[31:25];

   always_comb begin
      o_op = OP_NOP;
      case (opcode)
         OPC_OP_IMM: if (funct3 == 3'b000) o_op = OP_ADDI;
         OPC_OP: begin
            if (funct7 == 7'b0000000) begin
               case (funct3)
                  3'b000:  o_op = OP_ADD;
                  3'b100:  o_op = OP_XOR;
                  3'b110:  o_op = OP_OR;
                  3'b111:  o_op = OP_AND;
                  default: o_op = OP_NOP;
               endcase
            end else if ((funct7 == 7'b0100000) && (funct3 == 3'b000)) begin
               o_op = OP_SUB;
            end
         end
         OPC_LUI:    o_op = OP_LUI;
         OPC_JAL:    o_op = OP_JAL;
         OPC_BRANCH: begin
            if (funct3 == 3'b000)
               o_op = OP_BEQ;
            else if (funct3 == 3'b001)
               o_op = OP_BNE;
         end
         OPC_LOAD:   if (funct3 == 3'b010) o_op = OP_LW;
         OPC_STORE:  if (funct3 == 3'b010) o_op = OP_SW;
         default:    o_op = OP_NOP;
      endcase
   end

   // Immediate formats sign extended from bit 31
   assign imm_i = {{20{ir[31]}}, ir[31:20]};
   assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
   assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
   assign imm_u = {ir[31:12], 12'h000};
   assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

   always_comb begin
      case (o_op)
         OP_SW:         imm_sel = imm_s;
         OP_BEQ, OP_BNE: imm_sel = imm_b;
         OP_LUI:        imm_sel = imm_u;
         OP_JAL:        imm_sel = imm_j;
         default:       imm_sel = imm_i;
      endcase
   end

   assign o_imm      = imm_sel[i_cnt];
   assign o_rd_addr  = ir[11:7];
   assign o_rs1_addr = ir[19:15];
   assign o_rs2_addr = ir[24:20];

endmodule

`default_nettype wire

// ==== rtl/rv_state.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_state (
   input  wire                clk,
   input  wire                i_rst_n,
   input  wire                i_ibus_ack,
   input  wire                i_dbus_ack,
   input  wire rv_pkg::op_e   i_op,
   output rv_pkg::cnt_t       o_cnt,
   output logic               o_exec,
   output logic               o_branch_pass,
   output logic               o_wb,
   output logic               o_rd_wen,
   output logic               o_ibus_cyc,
   output logic               o_dbus_cyc,
   output logic               o_dbus_we
);
   import rv_pkg::*;

   state_e state_q;
   state_e state_d;
   cnt_t   cnt_q;
   logic   last;
   logic   counting;
   logic   is_branch;
   logic   is_mem;
   logic   writes_rd;

   assign last      = (cnt_q == 5'd31);
   assign is_branch = (i_op == OP_BEQ) || (i_op == OP_BNE);
   assign is_mem    = (i_op == OP_LW) || (i_op == OP_SW);

   always_comb begin
      case (i_op)
         OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LUI, OP_JAL: writes_rd = 1'b1;
         default: writes_rd = 1'b0;
      endcase
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_FETCH:  if (i_ibus_ack) state_d = ST_EXEC;
         ST_EXEC: begin
            if (last) begin
               if (is_branch)
                  state_d = ST_BRANCH;
               else if (is_mem)
                  state_d = ST_MEM;
               else
                  state_d = ST_FETCH;
            end
         end
         ST_BRANCH: if (last) state_d = ST_FETCH;
         // Loads get a writeback pass, stores go straight to fetch
         ST_MEM:    if (i_dbus_ack) state_d = (i_op == OP_LW) ? ST_WB : ST_FETCH;
         ST_WB:     if (last) state_d = ST_FETCH;
         default:   state_d = ST_FETCH;
      endcase
   end

   assign counting = o_exec | o_branch_pass | o_wb;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= ST_FETCH;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         // Wraps from 31 back to zero at the end of each pass
         cnt_q   <= counting ? cnt_q + 5'd1 : 5'd0;
      end
   end

   assign o_cnt         = cnt_q;
   assign o_exec        = (state_q == ST_EXEC);
   assign o_branch_pass = (state_q == ST_BRANCH);
   assign o_wb          = (state_q == ST_WB);
   assign o_rd_wen      = (o_exec && writes_rd) || o_wb;
   assign o_ibus_cyc    = (state_q == ST_FETCH);
   assign o_dbus_cyc    = (state_q == ST_MEM);
   assign o_dbus_we     = o_dbus_cyc && (i_op == OP_SW);

   // A bus cycle stays up until its ack
   a_ibus_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_ibus_cyc && !i_ibus_ack |=> o_ibus_cyc);

   a_dbus_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_dbus_cyc && !i_dbus_ack |=> o_dbus_cyc && $stable(o_dbus_we));

   // Memory ops write rd only in WB and branches never
   a_rd_wen_phase: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_rd_wen |-> o_wb || (o_exec && !is_branch && !is_mem));

endmodule

`default_nettype wire

// ==== rtl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

   // Data and address word
   typedef logic [31:0] word_t;

   // Bit index within a 32-cycle pass
   typedef logic [4:0] cnt_t;

   // Major opcodes of the supported subset
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   typedef enum logic [2:0] {
      ST_FETCH,
      ST_EXEC,
      ST_BRANCH,
      ST_MEM,
      ST_WB
   } state_e;

   typedef enum logic [3:0] {
      OP_ADDI,
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_LUI,
      OP_JAL,
      OP_BEQ,
      OP_BNE,
      OP_LW,
      OP_SW,
      OP_NOP
   } op_e;

endpackage

`default_nettype wire
